/* logic/enc_out_macros.svh */
`ifndef ENC_OUT_MACROS_SVH
`define ENC_OUT_MACROS_SVH

// line geometry, fixed by INCR16 on a 32-bit bus
`define ENC_WORD_W          32
`define ENC_BLOCK_W         128
`define ENC_BLOCKS_PER_LINE 4
`define ENC_BEATS           16
// also the destination alignment unit
`define ENC_LINE_BYTES      64

// AHB-Lite encodings
`define ENC_HTRANS_IDLE     2'b00
`define ENC_HTRANS_NONSEQ   2'b10
`define ENC_HTRANS_SEQ      2'b11
`define ENC_HSIZE_WORD      3'b010
`define ENC_HBURST_INCR16   3'b111

`endif

/* logic/enc_out_pkg.sv */
`include "enc_out_macros.svh"

package enc_out_pkg;

  // byte address on the AHB side
  typedef logic [31:0] addr_t;
  // one bus word
  typedef logic [`ENC_WORD_W-1:0] word_t;
  // one cipher output block
  typedef logic [`ENC_BLOCK_W-1:0] block_t;
  // beat number inside a 16-beat burst
  typedef logic [$clog2(`ENC_BEATS)-1:0] beat_idx_t;
  // block number inside a line
  typedef logic [$clog2(`ENC_BLOCKS_PER_LINE)-1:0] blk_idx_t;

  // writer address-phase FSM
  // LAST_DATA = addresses done, beat 15 data still on the bus
  typedef enum logic [1:0] {
    IDLE,
    BURST,
    LAST_DATA
  } wr_state_e;

  // life of one line slot
  typedef enum logic [1:0] {
    EMPTY,
    FILLING,
    FULL
  } slot_state_e;

endpackage

/* logic/line_xfer_if.sv */
interface line_xfer_if;

  // line offer, buffer to writer
  logic                   line_valid;
  enc_out_pkg::addr_t     line_addr;
  // writer takes the line and starts its burst
  logic                   line_ready;
  // word fetch by beat number
  enc_out_pkg::beat_idx_t beat_idx;
  enc_out_pkg::word_t     beat_data;
  // pulse when beat 15 data has been accepted
  logic                   line_done;

  modport buffer (
    output line_valid, line_addr, beat_data,
    input  line_ready, beat_idx, line_done
  );

  modport master (
    input  line_valid, line_addr, beat_data,
    output line_ready, beat_idx, line_done
  );

endinterface

/* logic/line_buffer.sv */
`include "enc_out_macros.svh"

module line_buffer (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  enc_out_pkg::addr_t  destination,
  input  logic                dest_updated,
  input  enc_out_pkg::block_t text_data,
  input  logic                text_valid,
  output logic                text_ready,
  line_xfer_if.buffer         lx
);

  // two ping-pong line slots
  enc_out_pkg::block_t      slot_blk [2][`ENC_BLOCKS_PER_LINE];
  enc_out_pkg::addr_t       slot_base [2];
  enc_out_pkg::slot_state_e slot_st [2];
  enc_out_pkg::blk_idx_t    slot_fill [2];
  // line already handed to the writer, waiting for line_done
  logic                     slot_sent [2];

  enc_out_pkg::addr_t    dest_q;
  // tail, next line to offer, oldest line to free
  logic                  fill_sel;
  logic                  offer_sel;
  logic                  free_sel;
  // slot whose burst is on the bus
  logic                  burst_sel;
  logic                  text_fire;
  logic                  line_fire;
  logic                  blk_last;
  enc_out_pkg::blk_idx_t beat_blk;

  // stall only when the tail slot still holds an unsent or unfinished line
  assign text_ready = (slot_st[fill_sel] != enc_out_pkg::FULL);
  assign text_fire  = text_valid && text_ready;
  assign blk_last   = (slot_fill[fill_sel] == `ENC_BLOCKS_PER_LINE - 1);

  assign lx.line_valid = (slot_st[offer_sel] == enc_out_pkg::FULL) && !slot_sent[offer_sel];
  assign lx.line_addr  = slot_base[offer_sel];
  assign line_fire     = lx.line_valid && lx.line_ready;

  // offer pointer moves on each handshake, so the burst slot is the other one
  assign burst_sel = ~offer_sel;
  // beat 4k+j -> word j of block k
  assign beat_blk  = lx.beat_idx[3:2];
  assign lx.beat_data =
    slot_blk[burst_sel][beat_blk][lx.beat_idx[1:0] * `ENC_WORD_W +: `ENC_WORD_W];

  // software destination register
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      dest_q <= '0;
    end
    else if (dest_updated)
    begin
      dest_q <= destination;
    end
  end

  // block storage and line base
  always_ff @(posedge HCLK)
  begin
    if (text_fire)
    begin
      slot_blk[fill_sel][slot_fill[fill_sel]] <= text_data;
      // base latched with block 0, a same-edge update wins
      if (slot_fill[fill_sel] == '0)
      begin
        slot_base[fill_sel] <= dest_updated ? destination : dest_q;
      end
    end
  end

  // slot bookkeeping
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      fill_sel  <= 1'b0;
      offer_sel <= 1'b0;
      free_sel  <= 1'b0;
      for (int s = 0; s < 2; s++)
      begin
        slot_st[s]   <= enc_out_pkg::EMPTY;
        slot_fill[s] <= '0;
        slot_sent[s] <= 1'b0;
      end
    end
    else
    begin
      if (text_fire)
      begin
        // pointer wraps to 0 after block 3
        slot_fill[fill_sel] <= slot_fill[fill_sel] + 1'b1;
        slot_st[fill_sel]   <= blk_last ? enc_out_pkg::FULL : enc_out_pkg::FILLING;
        if (blk_last)
        begin
          fill_sel <= ~fill_sel;
        end
      end
      if (line_fire)
      begin
        slot_sent[offer_sel] <= 1'b1;
        offer_sel            <= ~offer_sel;
      end
      // never the tail slot, that one is not FULL while filling
      if (lx.line_done)
      begin
        slot_st[free_sel]   <= enc_out_pkg::EMPTY;
        slot_sent[free_sel] <= 1'b0;
        free_sel            <= ~free_sel;
      end
    end
  end

  // INCR16 must not cross 1 KB, so every line starts on a 64-byte boundary
  a_line_aligned: assert property (@(posedge HCLK) disable iff (!HRESETn)
    lx.line_valid |-> ((lx.line_addr & (`ENC_LINE_BYTES - 1)) == 0));

  // producer holds the block while stalled
  a_text_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (text_valid && !text_ready) |=> (!text_valid || $stable(text_data)));

  // writer only completes lines it was given
  a_done_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
    lx.line_done |-> (slot_st[free_sel] == enc_out_pkg::FULL) && slot_sent[free_sel]);

endmodule

/* logic/ahb_burst_writer.sv */
`include "enc_out_macros.svh"

module ahb_burst_writer (
  input  logic               HCLK,
  input  logic               HRESETn,
  line_xfer_if.master        lx,
  input  logic               HREADY,
  input  logic               HRESP,
  output enc_out_pkg::addr_t HADDR,
  output logic               HWRITE,
  output logic [2:0]         HSIZE,
  output logic [2:0]         HBURST,
  output logic [1:0]         HTRANS,
  output enc_out_pkg::word_t HWDATA,
  output logic               bus_error
);

  enc_out_pkg::wr_state_e state;
  // beat on the address bus
  enc_out_pkg::beat_idx_t addr_beat;
  // beat whose data is on HWDATA
  enc_out_pkg::beat_idx_t data_beat;
  logic                   data_busy;

  logic addr_active;
  logic addr_acc;
  logic data_acc;
  logic addr_last;
  logic line_fire;

  assign addr_active = (HTRANS != `ENC_HTRANS_IDLE);
  assign addr_acc    = addr_active && HREADY;
  assign data_acc    = data_busy && HREADY;
  assign addr_last   = (addr_beat == `ENC_BEATS - 1);

  // write-only master, single burst type
  assign HWRITE = 1'b1;
  assign HSIZE  = `ENC_HSIZE_WORD;
  assign HBURST = `ENC_HBURST_INCR16;

  // take a new line when idle, or as the last address goes out
  always_comb
  begin
    case (state)
      enc_out_pkg::IDLE:      lx.line_ready = 1'b1;
      enc_out_pkg::BURST:     lx.line_ready = addr_last && HREADY;
      enc_out_pkg::LAST_DATA: lx.line_ready = HREADY;
      default:                lx.line_ready = 1'b0;
    endcase
  end

  assign line_fire    = lx.line_valid && lx.line_ready;
  assign lx.beat_idx  = addr_beat;
  // 16th accepted data phase ends the line
  assign lx.line_done = data_acc && (data_beat == `ENC_BEATS - 1);

  // address phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state     <= enc_out_pkg::IDLE;
      HTRANS    <= `ENC_HTRANS_IDLE;
      HADDR     <= '0;
      addr_beat <= '0;
    end
    else if (line_fire)
    begin
      // NONSEQ overlaps the previous line's beat 15 data
      state     <= enc_out_pkg::BURST;
      HTRANS    <= `ENC_HTRANS_NONSEQ;
      HADDR     <= lx.line_addr;
      addr_beat <= '0;
    end
    else
    begin
      case (state)
        enc_out_pkg::BURST:
        begin
          // wait states freeze the address phase
          if (HREADY)
          begin
            if (addr_last)
            begin
              state  <= enc_out_pkg::LAST_DATA;
              HTRANS <= `ENC_HTRANS_IDLE;
            end
            else
            begin
              HADDR     <= HADDR + (`ENC_WORD_W / 8);
              HTRANS    <= `ENC_HTRANS_SEQ;
              addr_beat <= addr_beat + 1'b1;
            end
          end
        end
        enc_out_pkg::LAST_DATA:
        begin
          if (data_acc)
          begin
            state <= enc_out_pkg::IDLE;
          end
        end
        default:
        begin
          state <= enc_out_pkg::IDLE;
        end
      endcase
    end
  end

  // data phase, one beat behind the address
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      data_busy <= 1'b0;
      data_beat <= '0;
      HWDATA    <= '0;
    end
    else if (addr_acc)
    begin
      data_busy <= 1'b1;
      data_beat <= addr_beat;
      HWDATA    <= lx.beat_data;
    end
    else if (data_acc)
    begin
      data_busy <= 1'b0;
    end
  end

  // sticky error, burst still runs to the end
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      bus_error <= 1'b0;
    end
    else if (data_busy && HRESP)
    begin
      bus_error <= 1'b1;
    end
  end

  // no IDLE before beat 15, whatever HREADY does
  a_no_idle_mid_burst: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (addr_active && !addr_last) |=> addr_active);

  // address phase held across wait states
  a_addr_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (addr_active && !HREADY) |=> ($stable(HADDR) && $stable(HTRANS)));

endmodule

/* logic/enc_out_top.sv */
module enc_out_top (
  input  logic                HCLK,
  input  logic                HRESETn,
  // cipher side
  input  enc_out_pkg::addr_t  destination,
  input  logic                dest_updated,
  input  enc_out_pkg::block_t text_data,
  input  logic                text_valid,
  output logic                text_ready,
  output logic                bus_error,
  // AHB-Lite master
  input  logic                HREADY,
  input  logic                HRESP,
  // write-only, read data ignored
  input  enc_out_pkg::word_t  HRDATA,
  output enc_out_pkg::addr_t  HADDR,
  output logic                HWRITE,
  output logic [2:0]          HSIZE,
  output logic [2:0]          HBURST,
  output logic [1:0]          HTRANS,
  output enc_out_pkg::word_t  HWDATA
);

  line_xfer_if lx0 ();

  // blocks in, lines out
  line_buffer buf0 (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .destination  (destination),
    .dest_updated (dest_updated),
    .text_data    (text_data),
    .text_valid   (text_valid),
    .text_ready   (text_ready),
    .lx           (lx0.buffer)
  );

  // one INCR16 write per line
  ahb_burst_writer wr0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .lx        (lx0.master),
    .HREADY    (HREADY),
    .HRESP     (HRESP),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HBURST    (HBURST),
    .HTRANS    (HTRANS),
    .HWDATA    (HWDATA),
    .bus_error (bus_error)
  );

endmodule

/* tb/ahb_mem_responder.sv */
module ahb_mem_responder (
  input  logic               HCLK,
  input  logic               HRESETn,
  input  enc_out_pkg::addr_t HADDR,
  input  logic [1:0]         HTRANS,
  input  logic               HWRITE,
  input  enc_out_pkg::word_t HWDATA,
  // long stall request from the testbench
  input  logic               hold,
  output logic               HREADY,
  output logic               HRESP
);
  timeunit 1ns;
  timeprecision 100ps;

  // every completed write, in bus order
  enc_out_pkg::addr_t wr_addr_q [$];
  enc_out_pkg::word_t wr_data_q [$];
  int                 err_count = 0;

  // data phase in flight
  logic               dp_valid  = 1'b0;
  enc_out_pkg::addr_t dp_addr   = '0;
  int                 wait_cnt  = 0;
  logic               dp_err    = 1'b0;
  // first error cycle already given
  logic               err_stage = 1'b0;
  int                 acc_count = 0;

  // low for wait states, the hold request and the first error cycle
  assign HREADY = !dp_valid || ((wait_cnt == 0) && !hold && !(dp_err && !err_stage));
  assign HRESP  = dp_valid && dp_err && (wait_cnt == 0);

  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      dp_valid  <= 1'b0;
      wait_cnt  <= 0;
      dp_err    <= 1'b0;
      err_stage <= 1'b0;
      acc_count <= 0;
    end
    else if (HREADY)
    begin
      // data phase completes here
      if (dp_valid)
      begin
        wr_addr_q.push_back(dp_addr);
        wr_data_q.push_back(HWDATA);
        if (dp_err)
          err_count++;
      end
      // NONSEQ or SEQ write starts a new data phase
      if (HTRANS[1] && HWRITE)
      begin
        dp_valid  <= 1'b1;
        dp_addr   <= HADDR;
        wait_cnt  <= $urandom_range(0, 3);
        // two chosen beats get an ERROR response
        dp_err    <= (acc_count == 37) || (acc_count == 555);
        err_stage <= 1'b0;
        acc_count <= acc_count + 1;
      end
      else
      begin
        dp_valid <= 1'b0;
      end
    end
    else
    begin
      if (wait_cnt != 0)
        wait_cnt <= wait_cnt - 1;
      else if (dp_err)
        err_stage <= 1'b1;
    end
  end

endmodule

/* tb/enc_out_tb.sv */
`include "enc_out_macros.svh"

module enc_out_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LINES      = 40;
  localparam int NUM_BLOCKS     = NUM_LINES * `ENC_BLOCKS_PER_LINE;
  localparam int TIMEOUT_CYCLES = NUM_LINES * 16 * 4 + NUM_LINES * 4 * 4 + 500;
  // long stall window, with gap-free blocks around it
  localparam int STALL_AT       = 80;
  localparam int STALL_CYCLES   = 150;

  logic HCLK, HRESETn, dest_updated, text_valid, text_ready, bus_error;
  logic HREADY, HRESP, HWRITE, hold;
  enc_out_pkg::addr_t  destination, HADDR;
  enc_out_pkg::block_t text_data;
  enc_out_pkg::word_t  HRDATA, HWDATA;
  logic [2:0] HSIZE, HBURST;
  logic [1:0] HTRANS;

  // reference model
  enc_out_pkg::addr_t exp_addr_q [$];
  enc_out_pkg::word_t exp_data_q [$];
  enc_out_pkg::addr_t m_dest, m_base;
  int m_blk;

  int blk_sent = 0;
  int cycle_cnt = 0;
  int mismatch_cnt = 0;
  int fail_cnt = 0;
  // bus protocol tracking
  int beat_cnt = 0;
  logic err_flag = 1'b0;
  logic ready_dropped = 1'b0;
  logic prev_ok = 1'b0;
  logic prev_hready;
  enc_out_pkg::addr_t prev_haddr;
  enc_out_pkg::word_t prev_hwdata;
  logic [1:0] prev_htrans;

  enc_out_top dut0 (
    .HCLK(HCLK), .HRESETn(HRESETn), .destination(destination), .dest_updated(dest_updated),
    .text_data(text_data), .text_valid(text_valid), .text_ready(text_ready),
    .bus_error(bus_error), .HREADY(HREADY), .HRESP(HRESP), .HRDATA(HRDATA), .HADDR(HADDR),
    .HWRITE(HWRITE), .HSIZE(HSIZE), .HBURST(HBURST), .HTRANS(HTRANS), .HWDATA(HWDATA)
  );

  ahb_mem_responder mem0 (
    .HCLK(HCLK), .HRESETn(HRESETn), .HADDR(HADDR), .HTRANS(HTRANS), .HWRITE(HWRITE),
    .HWDATA(HWDATA), .hold(hold), .HREADY(HREADY), .HRESP(HRESP)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] act);
    $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    mismatch_cnt++;
  endtask

  function automatic enc_out_pkg::addr_t rand_dest();
    logic [31:0] r;
    r = $urandom();
    // line aligned
    return {r[31:6], 6'b0};
  endfunction

  function automatic enc_out_pkg::block_t rand_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // forced updates: with block 0 of some lines, mid-line on others
  function automatic logic update_due();
    return (((blk_sent / 4) % 8 == 3) && (blk_sent % 4 == 0)) ||
           (((blk_sent / 4) % 8 == 5) && (blk_sent % 4 == 2));
  endfunction

  function automatic logic stream_phase();
    return (blk_sent >= STALL_AT) && (blk_sent < STALL_AT + 48);
  endfunction

  task automatic check_reset_values();
    if (HTRANS !== `ENC_HTRANS_IDLE) report_mismatch("HTRANS", `ENC_HTRANS_IDLE, HTRANS);
    if (HADDR !== '0) report_mismatch("HADDR", 0, HADDR);
    if (HWDATA !== '0) report_mismatch("HWDATA", 0, HWDATA);
    if (bus_error !== 1'b0) report_mismatch("bus_error", 0, bus_error);
    if (text_ready !== 1'b1) report_mismatch("text_ready", 1, text_ready);
  endtask

  task automatic compare_writes();
    int n;
    n = mem0.wr_addr_q.size();
    if (n != exp_addr_q.size())
    begin
      report_mismatch("write count", exp_addr_q.size(), n);
      if (exp_addr_q.size() < n)
        n = exp_addr_q.size();
    end
    // order matters, beat 4k+j of each line
    for (int i = 0; i < n; i++)
    begin
      if (mem0.wr_addr_q[i] !== exp_addr_q[i])
        report_mismatch($sformatf("HADDR of write %0d", i), exp_addr_q[i], mem0.wr_addr_q[i]);
      if (mem0.wr_data_q[i] !== exp_data_q[i])
        report_mismatch($sformatf("HWDATA of write %0d", i), exp_data_q[i], mem0.wr_data_q[i]);
    end
  endtask

  task automatic check_final_state();
    logic exp_err;
    exp_err = (mem0.err_count != 0);
    if (!ready_dropped)
    begin
      $display("text_ready never dropped during the long HREADY stall");
      fail_cnt++;
    end
    if (mem0.err_count == 0)
    begin
      $display("memory model gave no error response, error path not exercised");
      fail_cnt++;
    end
    if (bus_error !== exp_err) report_mismatch("bus_error", exp_err, bus_error);
    if (HTRANS !== `ENC_HTRANS_IDLE) report_mismatch("HTRANS", `ENC_HTRANS_IDLE, HTRANS);
  endtask

  // model: base taken with block 0, same-edge update wins
  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      m_dest = '0;
      m_blk  = 0;
    end
    else
    begin
      if (text_valid && text_ready)
      begin
        if (m_blk == 0)
          m_base = dest_updated ? destination : m_dest;
        for (int j = 0; j < 4; j++)
        begin
          exp_addr_q.push_back(m_base + 4 * (4 * m_blk + j));
          exp_data_q.push_back(text_data[32 * j +: 32]);
        end
        m_blk = (m_blk + 1) % 4;
      end
      if (dest_updated)
        m_dest = destination;
    end
  end

  // bus protocol monitor
  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      prev_ok = 1'b0;
    end
    else
    begin
      // wait state froze the whole bus
      if (prev_ok && !prev_hready)
      begin
        if (HADDR !== prev_haddr) report_mismatch("HADDR", prev_haddr, HADDR);
        if (HTRANS !== prev_htrans) report_mismatch("HTRANS", prev_htrans, HTRANS);
        if (HWDATA !== prev_hwdata) report_mismatch("HWDATA", prev_hwdata, HWDATA);
      end
      if (HTRANS !== `ENC_HTRANS_IDLE)
      begin
        if (HTRANS !== ((beat_cnt == 0) ? `ENC_HTRANS_NONSEQ : `ENC_HTRANS_SEQ))
          report_mismatch("HTRANS", (beat_cnt == 0) ? `ENC_HTRANS_NONSEQ : `ENC_HTRANS_SEQ, HTRANS);
        if (HWRITE !== 1'b1) report_mismatch("HWRITE", 1, HWRITE);
        if (HSIZE !== `ENC_HSIZE_WORD) report_mismatch("HSIZE", `ENC_HSIZE_WORD, HSIZE);
        if (HBURST !== `ENC_HBURST_INCR16) report_mismatch("HBURST", `ENC_HBURST_INCR16, HBURST);
        if (HREADY)
          beat_cnt = (beat_cnt + 1) % 16;
      end
      else if (beat_cnt != 0)
      begin
        $display("HTRANS went IDLE after beat %0d of a burst at %0t", beat_cnt, $time);
        fail_cnt++;
      end
      // sticky, one cycle after the error response
      if (bus_error !== err_flag) report_mismatch("bus_error", err_flag, bus_error);
      if (HRESP)
        err_flag = 1'b1;
      if (hold && text_valid && !text_ready)
        ready_dropped = 1'b1;
      prev_ok     = 1'b1;
      prev_hready = HREADY;
      prev_haddr  = HADDR;
      prev_htrans = HTRANS;
      prev_hwdata = HWDATA;
    end
  end

  initial
  begin : main_seq
    int seed_val;
    logic fire;
    seed_val = $urandom(32'h8e71_6beb);
    HRESETn = 1'b0;
    destination = '0;
    dest_updated = 1'b0;
    text_data = '0;
    text_valid = 1'b0;
    HRDATA = '0;
    repeat (5) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;
    check_reset_values();
    while (blk_sent < NUM_BLOCKS)
    begin
      // random gaps, none around the stall
      if (!text_valid && (stream_phase() || $urandom_range(0, 3) != 0))
      begin
        text_valid = 1'b1;
        text_data  = rand_block();
      end
      dest_updated = update_due() || ($urandom_range(0, 9) == 0);
      if (dest_updated)
        destination = rand_dest();
      @(posedge HCLK);
      fire = text_valid && text_ready;
      #2;
      if (fire)
      begin
        blk_sent++;
        text_valid = 1'b0;
      end
    end
    dest_updated = 1'b0;
    // drain, then make sure nothing extra shows up
    while (mem0.wr_addr_q.size() < exp_addr_q.size())
      @(posedge HCLK);
    repeat (40) @(posedge HCLK);
    compare_writes();
    check_final_state();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // long HREADY-low run while blocks keep coming
  initial
  begin : stall_seq
    hold = 1'b0;
    wait (blk_sent >= STALL_AT);
    @(posedge HCLK);
    #2;
    hold = 1'b1;
    repeat (STALL_CYCLES) @(posedge HCLK);
    #2;
    hold = 1'b0;
  end

  initial
  begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge HCLK);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, writes still outstanding", cycle_cnt);
    fail_cnt++;
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* enc_out_top.f */
+incdir+logic
logic/enc_out_pkg.sv
logic/line_xfer_if.sv
logic/line_buffer.sv
logic/ahb_burst_writer.sv
logic/enc_out_top.sv
tb/ahb_mem_responder.sv
tb/enc_out_tb.sv
